// File: source/noc_out_defs.svh
// NoC output port parameters
// Route count, field widths and the APB register map
`ifndef NOC_OUT_DEFS_SVH
`define NOC_OUT_DEFS_SVH

// Input routes feeding this output port
`define NOC_NUM_ROUTES 4

// Flit field widths, node id is x and y of 4 bits each
`define NOC_PAYLOAD_W 32
`define NOC_ID_W 8

// APB address width and register offsets
`define NOC_APB_AW 4
`define NOC_REG_REDOP 4'h0
`define NOC_REG_MASK 4'h4
`define NOC_REG_UCNT 4'h8
`define NOC_REG_RCNT 4'hC

`endif

// File: source/noc_out_pkg.sv
// NoC output port types
// Vector typedefs and enums shared by the RTL and the testbench
`default_nettype none

`include "noc_out_defs.svh"

package noc_out_pkg;

  typedef logic [`NOC_PAYLOAD_W-1:0] payload_t;
  typedef logic [`NOC_ID_W-1:0] node_id_t;

  // One bit per input route
  typedef logic [`NOC_NUM_ROUTES-1:0] route_vec_t;

  typedef logic [31:0] count_t;
  typedef logic [31:0] apb_data_t;

  typedef enum logic [1:0] {
    UNICAST = 2'd0,
    REDUCE  = 2'd1
  } commtype_e;

  // Reduction operators, max compares unsigned
  typedef enum logic [1:0] {
    RED_ADD = 2'd0,
    RED_AND = 2'd1,
    RED_OR  = 2'd2,
    RED_MAX = 2'd3
  } redop_e;

  typedef enum logic {
    WH_IDLE   = 1'b0,
    WH_LOCKED = 1'b1
  } wh_state_e;

endpackage

`default_nettype wire

// File: source/flit_if.sv
// Single flit stream with valid/ready handshake
// Sender holds valid and data stable until the transfer
`timescale 1ns/1ns
`default_nettype none

interface flit_if;

  logic                   valid;
  logic                   ready;
  noc_out_pkg::commtype_e commtype;
  logic                   last;
  noc_out_pkg::node_id_t  dst;
  noc_out_pkg::payload_t  payload;

  modport sender (
    output valid, commtype, last, dst, payload,
    input  ready
  );

  modport receiver (
    input  valid, commtype, last, dst, payload,
    output ready
  );

endinterface

`default_nettype wire

// File: source/wormhole_lock_fsm.sv
// Wormhole grant FSM for unicast traffic
// Round-robin pick among requesting routes, locked on the picked
// route until the last flit of its packet has transferred
`timescale 1ns/1ns
`default_nettype none

`include "noc_out_defs.svh"

module wormhole_lock_fsm (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  noc_out_pkg::route_vec_t req_i,
  input  noc_out_pkg::route_vec_t last_i,
  input  logic                    fire_i,
  output noc_out_pkg::route_vec_t grant_o,
  output logic                    locked_o
);

  localparam int NUM = `NOC_NUM_ROUTES;
  localparam int PTR_W = (NUM > 1) ? $clog2(NUM) : 1;

  noc_out_pkg::wh_state_e state_q;
  // Last granted route, also the held route while locked
  logic [PTR_W-1:0] ptr_q;
  logic [PTR_W-1:0] pick_idx;
  logic             pick_found;
  logic [PTR_W-1:0] cur_idx;

  // Search starts one past the previous grant and wraps around
  always_comb begin
    pick_found = 1'b0;
    pick_idx   = ptr_q;
    for (int i = 1; i <= NUM; i++) begin
      if (!pick_found && req_i[(int'(ptr_q) + i) % NUM]) begin
        pick_found = 1'b1;
        pick_idx   = PTR_W'((int'(ptr_q) + i) % NUM);
      end
    end
  end

  assign locked_o = (state_q == noc_out_pkg::WH_LOCKED);
  assign cur_idx  = locked_o ? ptr_q : pick_idx;

  always_comb begin
    grant_o = '0;
    if (locked_o || pick_found) begin
      grant_o[cur_idx] = 1'b1;
    end
  end

  // A transfer records the served route; non-last flits lock onto it
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= noc_out_pkg::WH_IDLE;
      ptr_q   <= '0;
    end else if (fire_i) begin
      ptr_q <= cur_idx;
      if (last_i[cur_idx]) begin
        state_q <= noc_out_pkg::WH_IDLE;
      end else begin
        state_q <= noc_out_pkg::WH_LOCKED;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/reduction_combiner.sv
// Reduction combiner for collective flits
// Waits for a flit on every member route, then folds the payloads
// with the configured operator into one output flit
`timescale 1ns/1ns
`default_nettype none

`include "noc_out_defs.svh"

module reduction_combiner (
  input  noc_out_pkg::route_vec_t                       valid_i,
  input  noc_out_pkg::commtype_e [`NOC_NUM_ROUTES-1:0]  commtype_i,
  input  noc_out_pkg::route_vec_t                       last_i,
  input  noc_out_pkg::node_id_t [`NOC_NUM_ROUTES-1:0]   dst_i,
  input  noc_out_pkg::payload_t [`NOC_NUM_ROUTES-1:0]   payload_i,
  input  noc_out_pkg::route_vec_t                       member_mask_i,
  input  noc_out_pkg::redop_e                           redop_i,
  output noc_out_pkg::route_vec_t                       ready_o,
  flit_if.sender                                        red
);

  noc_out_pkg::route_vec_t is_red;
  noc_out_pkg::payload_t   acc;
  noc_out_pkg::node_id_t   first_dst;
  logic                    all_last;

  always_comb begin
    for (int i = 0; i < `NOC_NUM_ROUTES; i++) begin
      is_red[i] = valid_i[i] && (commtype_i[i] == noc_out_pkg::REDUCE);
    end
  end

  // Lowest-index member seeds the fold and supplies dst
  always_comb begin : fold
    logic seen;
    seen      = 1'b0;
    acc       = '0;
    first_dst = '0;
    all_last  = 1'b1;
    for (int i = 0; i < `NOC_NUM_ROUTES; i++) begin
      if (member_mask_i[i]) begin
        all_last = all_last & last_i[i];
        if (!seen) begin
          seen      = 1'b1;
          acc       = payload_i[i];
          first_dst = dst_i[i];
        end else begin
          case (redop_i)
            noc_out_pkg::RED_ADD: acc = acc + payload_i[i];
            noc_out_pkg::RED_AND: acc = acc & payload_i[i];
            noc_out_pkg::RED_OR:  acc = acc | payload_i[i];
            default:              acc = (payload_i[i] > acc) ? payload_i[i] : acc;
          endcase
        end
      end
    end
  end

  // Every member present with a reduction flit, empty mask never fires
  assign red.valid    = (|member_mask_i) && ((is_red & member_mask_i) == member_mask_i);
  assign red.commtype = noc_out_pkg::REDUCE;
  assign red.last     = all_last;
  assign red.dst      = first_dst;
  assign red.payload  = acc;

  // All members are consumed together
  assign ready_o = (red.valid && red.ready) ? member_mask_i : '0;

endmodule

`default_nettype wire

// File: source/traffic_counter.sv
// Output traffic counters
// One saturating count per communication type, cleared on request
`timescale 1ns/1ns
`default_nettype none

module traffic_counter (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                fire_i,
  input  logic                is_reduce_i,
  input  logic                clear_i,
  output noc_out_pkg::count_t ucnt_o,
  output noc_out_pkg::count_t rcnt_o
);

  noc_out_pkg::count_t ucnt_q;
  noc_out_pkg::count_t rcnt_q;

  // Clear wins over a same-cycle increment
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      ucnt_q <= '0;
      rcnt_q <= '0;
    end else if (fire_i) begin
      if (is_reduce_i) begin
        if (rcnt_q != '1) begin
          rcnt_q <= rcnt_q + 1'b1;
        end
      end else if (ucnt_q != '1) begin
        ucnt_q <= ucnt_q + 1'b1;
      end
    end
  end

  assign ucnt_o = ucnt_q;
  assign rcnt_o = rcnt_q;

endmodule

`default_nettype wire

// File: source/port_cfg_apb.sv
// APB configuration block for the output port
// Holds the reduction operator and member mask, reads back the counters
// Zero wait states; unmapped addresses answer with pslverr
`timescale 1ns/1ns
`default_nettype none

`include "noc_out_defs.svh"

module port_cfg_apb (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic [`NOC_APB_AW-1:0]  paddr_i,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  noc_out_pkg::apb_data_t  pwdata_i,
  output noc_out_pkg::apb_data_t  prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o,
  input  noc_out_pkg::count_t     ucnt_i,
  input  noc_out_pkg::count_t     rcnt_i,
  output noc_out_pkg::redop_e     redop_o,
  output noc_out_pkg::route_vec_t member_mask_o,
  output logic                    clear_o
);

  noc_out_pkg::redop_e     redop_q;
  noc_out_pkg::route_vec_t mask_q;
  logic                    access;
  logic                    addr_hit;
  logic                    wr_en;

  assign access = psel_i && penable_i;
  assign wr_en  = access && pwrite_i && addr_hit;

  // Address decode and read mux
  always_comb begin
    addr_hit = 1'b1;
    prdata_o = '0;
    case (paddr_i)
      `NOC_REG_REDOP: prdata_o = noc_out_pkg::apb_data_t'(redop_q);
      `NOC_REG_MASK:  prdata_o = noc_out_pkg::apb_data_t'(mask_q);
      `NOC_REG_UCNT:  prdata_o = ucnt_i;
      `NOC_REG_RCNT:  prdata_o = rcnt_i;
      default:        addr_hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      redop_q <= noc_out_pkg::RED_ADD;
      mask_q  <= '1;
    end else if (wr_en) begin
      if (paddr_i == `NOC_REG_REDOP) begin
        redop_q <= noc_out_pkg::redop_e'(pwdata_i[1:0]);
      end
      if (paddr_i == `NOC_REG_MASK) begin
        mask_q <= pwdata_i[`NOC_NUM_ROUTES-1:0];
      end
    end
  end

  // Either counter address clears both counts
  assign clear_o = wr_en && ((paddr_i == `NOC_REG_UCNT) || (paddr_i == `NOC_REG_RCNT));

  assign pready_o      = 1'b1;
  assign pslverr_o     = access && !addr_hit;
  assign redop_o       = redop_q;
  assign member_mask_o = mask_q;

endmodule

`default_nettype wire

// File: source/noc_output_arbiter.sv
// Output arbiter of one router port
// Unicasts go through the wormhole grant, reductions through the combiner;
// reductions take the output only between unicast packets
`timescale 1ns/1ns
`default_nettype none

`include "noc_out_defs.svh"

module noc_output_arbiter (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  noc_out_pkg::route_vec_t                       valid_i,
  output noc_out_pkg::route_vec_t                       ready_o,
  input  noc_out_pkg::commtype_e [`NOC_NUM_ROUTES-1:0]  commtype_i,
  input  noc_out_pkg::route_vec_t                       last_i,
  input  noc_out_pkg::node_id_t [`NOC_NUM_ROUTES-1:0]   dst_i,
  input  noc_out_pkg::payload_t [`NOC_NUM_ROUTES-1:0]   payload_i,
  input  noc_out_pkg::route_vec_t                       member_mask_i,
  input  noc_out_pkg::redop_e                           redop_i,
  flit_if.sender                                        out
);

  flit_if uni_s ();
  flit_if red_s ();
  flit_if mrg_s ();

  noc_out_pkg::route_vec_t uni_req;
  noc_out_pkg::route_vec_t grant;
  noc_out_pkg::route_vec_t red_ready;
  logic                    locked;
  logic                    uni_fire;
  logic                    sel_red;

  // Split valid by communication type
  always_comb begin
    for (int i = 0; i < `NOC_NUM_ROUTES; i++) begin
      uni_req[i] = valid_i[i] && (commtype_i[i] != noc_out_pkg::REDUCE);
    end
  end

  assign uni_fire = uni_s.valid && uni_s.ready;

  wormhole_lock_fsm u_wh_fsm (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (uni_req),
    .last_i   (last_i),
    .fire_i   (uni_fire),
    .grant_o  (grant),
    .locked_o (locked)
  );

  // One-hot mux of the granted route onto the unicast stream
  always_comb begin
    uni_s.last    = 1'b0;
    uni_s.dst     = '0;
    uni_s.payload = '0;
    for (int i = 0; i < `NOC_NUM_ROUTES; i++) begin
      if (grant[i]) begin
        uni_s.last    = last_i[i];
        uni_s.dst     = dst_i[i];
        uni_s.payload = payload_i[i];
      end
    end
  end

  assign uni_s.valid    = |(uni_req & grant);
  assign uni_s.commtype = noc_out_pkg::UNICAST;

  reduction_combiner u_red_comb (
    .valid_i       (valid_i),
    .commtype_i    (commtype_i),
    .last_i        (last_i),
    .dst_i         (dst_i),
    .payload_i     (payload_i),
    .member_mask_i (member_mask_i),
    .redop_i       (redop_i),
    .ready_o       (red_ready),
    .red           (red_s.sender)
  );

  // Reduction wins only at a packet boundary
  assign sel_red = red_s.valid && !locked;

  assign mrg_s.valid    = sel_red ? red_s.valid    : uni_s.valid;
  assign mrg_s.commtype = sel_red ? red_s.commtype : uni_s.commtype;
  assign mrg_s.last     = sel_red ? red_s.last     : uni_s.last;
  assign mrg_s.dst      = sel_red ? red_s.dst      : uni_s.dst;
  assign mrg_s.payload  = sel_red ? red_s.payload  : uni_s.payload;

  assign red_s.ready = sel_red && mrg_s.ready;
  assign uni_s.ready = !sel_red && mrg_s.ready;

  // Each route takes ready from the stream that owns its flit
  assign ready_o = red_ready | (grant & uni_req & {`NOC_NUM_ROUTES{uni_s.ready}});

  assign out.valid    = mrg_s.valid;
  assign out.commtype = mrg_s.commtype;
  assign out.last     = mrg_s.last;
  assign out.dst      = mrg_s.dst;
  assign out.payload  = mrg_s.payload;
  assign mrg_s.ready  = out.ready;

endmodule

`default_nettype wire

// File: source/noc_output_port.sv
// NoC router output port, top level
// Joins the output arbiter, APB configuration and traffic counters
`timescale 1ns/1ns
`default_nettype none

`include "noc_out_defs.svh"

module noc_output_port (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  // APB configuration
  input  logic [`NOC_APB_AW-1:0]                        paddr_i,
  input  logic                                          psel_i,
  input  logic                                          penable_i,
  input  logic                                          pwrite_i,
  input  noc_out_pkg::apb_data_t                        pwdata_i,
  output noc_out_pkg::apb_data_t                        prdata_o,
  output logic                                          pready_o,
  output logic                                          pslverr_o,
  // Input routes
  input  noc_out_pkg::route_vec_t                       in_valid_i,
  output noc_out_pkg::route_vec_t                       in_ready_o,
  input  noc_out_pkg::commtype_e [`NOC_NUM_ROUTES-1:0]  in_commtype_i,
  input  noc_out_pkg::route_vec_t                       in_last_i,
  input  noc_out_pkg::node_id_t [`NOC_NUM_ROUTES-1:0]   in_dst_i,
  input  noc_out_pkg::payload_t [`NOC_NUM_ROUTES-1:0]   in_payload_i,
  // Output flit stream
  output logic                                          out_valid_o,
  input  logic                                          out_ready_i,
  output noc_out_pkg::commtype_e                        out_commtype_o,
  output logic                                          out_last_o,
  output noc_out_pkg::node_id_t                         out_dst_o,
  output noc_out_pkg::payload_t                         out_payload_o
);

  flit_if out_s ();

  noc_out_pkg::redop_e     redop;
  noc_out_pkg::route_vec_t member_mask;
  noc_out_pkg::count_t     ucnt;
  noc_out_pkg::count_t     rcnt;
  logic                    cnt_clear;
  logic                    out_fire;
  logic                    out_is_reduce;

  noc_output_arbiter u_arbiter (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .valid_i       (in_valid_i),
    .ready_o       (in_ready_o),
    .commtype_i    (in_commtype_i),
    .last_i        (in_last_i),
    .dst_i         (in_dst_i),
    .payload_i     (in_payload_i),
    .member_mask_i (member_mask),
    .redop_i       (redop),
    .out           (out_s.sender)
  );

  assign out_valid_o    = out_s.valid;
  assign out_commtype_o = out_s.commtype;
  assign out_last_o     = out_s.last;
  assign out_dst_o      = out_s.dst;
  assign out_payload_o  = out_s.payload;
  assign out_s.ready    = out_ready_i;

  assign out_fire      = out_s.valid & out_s.ready;
  assign out_is_reduce = (out_s.commtype == noc_out_pkg::REDUCE);

  port_cfg_apb u_cfg (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .paddr_i       (paddr_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .pwdata_i      (pwdata_i),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .ucnt_i        (ucnt),
    .rcnt_i        (rcnt),
    .redop_o       (redop),
    .member_mask_o (member_mask),
    .clear_o       (cnt_clear)
  );

  traffic_counter u_counter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .fire_i      (out_fire),
    .is_reduce_i (out_is_reduce),
    .clear_i     (cnt_clear),
    .ucnt_o      (ucnt),
    .rcnt_o      (rcnt)
  );

endmodule

`default_nettype wire

// File: testbench/tb_noc_output_port.sv
// Testbench for the NoC router output port
// Directed tests for APB registers, wormhole unicast, reductions,
// reduction priority at packet boundaries and the traffic counters
`timescale 1ns/1ns
`default_nettype none

`include "noc_out_defs.svh"

module tb_noc_output_port;

  localparam int NUM = `NOC_NUM_ROUTES;

  // Cycle budget per test, summed for the watchdog
  localparam int BUDGET_REGS       = 200;
  localparam int BUDGET_SINGLE     = 200;
  localparam int BUDGET_CONTENTION = 600;
  localparam int BUDGET_REDUCE     = 600;
  localparam int BUDGET_MIXED      = 200;
  localparam int BUDGET_COUNTERS   = 200;
  localparam int WATCHDOG_CYCLES   = BUDGET_REGS + BUDGET_SINGLE + BUDGET_CONTENTION
                                   + BUDGET_REDUCE + BUDGET_MIXED + BUDGET_COUNTERS;

  typedef struct packed {
    noc_out_pkg::commtype_e ct;
    logic                   last;
    noc_out_pkg::node_id_t  dst;
    noc_out_pkg::payload_t  payload;
  } flit_t;

  logic                                         clk_i;
  logic                                         rst_n_i;
  logic [`NOC_APB_AW-1:0]                       paddr_i;
  logic                                         psel_i;
  logic                                         penable_i;
  logic                                         pwrite_i;
  noc_out_pkg::apb_data_t                       pwdata_i;
  noc_out_pkg::apb_data_t                       prdata_o;
  logic                                         pready_o;
  logic                                         pslverr_o;
  noc_out_pkg::route_vec_t                      in_valid_i;
  noc_out_pkg::route_vec_t                      in_ready_o;
  noc_out_pkg::commtype_e [`NOC_NUM_ROUTES-1:0] in_commtype_i;
  noc_out_pkg::route_vec_t                      in_last_i;
  noc_out_pkg::node_id_t [`NOC_NUM_ROUTES-1:0]  in_dst_i;
  noc_out_pkg::payload_t [`NOC_NUM_ROUTES-1:0]  in_payload_i;
  logic                                         out_valid_o;
  logic                                         out_ready_i;
  noc_out_pkg::commtype_e                       out_commtype_o;
  logic                                         out_last_o;
  noc_out_pkg::node_id_t                        out_dst_o;
  noc_out_pkg::payload_t                        out_payload_o;

  // Pending input flits and the expected unicast order per route
  flit_t route_q [NUM][$];
  flit_t exp_q [NUM][$];
  flit_t captured [$];

  noc_out_pkg::route_vec_t route_fire;
  noc_out_pkg::count_t     exp_ucnt;
  noc_out_pkg::count_t     exp_rcnt;
  logic                    bp_en;
  integer                  seed;

  noc_output_port uut (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .paddr_i        (paddr_i),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .pwdata_i       (pwdata_i),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .in_commtype_i  (in_commtype_i),
    .in_last_i      (in_last_i),
    .in_dst_i       (in_dst_i),
    .in_payload_i   (in_payload_i),
    .out_valid_o    (out_valid_o),
    .out_ready_i    (out_ready_i),
    .out_commtype_o (out_commtype_o),
    .out_last_o     (out_last_o),
    .out_dst_o      (out_dst_o),
    .out_payload_o  (out_payload_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: tests still running after %0d clock cycles", WATCHDOG_CYCLES);
    end_with_failure();
  end

  // Route sources; a route loads its next flit when idle or after a transfer
  initial begin : route_driver
    flit_t f;
    seed        = 27287;
    in_valid_i  = '0;
    in_last_i   = '0;
    in_dst_i    = '0;
    in_payload_i = '0;
    out_ready_i = 1'b1;
    for (int i = 0; i < NUM; i++) begin
      in_commtype_i[i] = noc_out_pkg::UNICAST;
    end
    forever begin
      @(posedge clk_i);
      for (int i = 0; i < NUM; i++) begin
        if (!in_valid_i[i] || route_fire[i]) begin
          if (route_q[i].size() > 0) begin
            f = route_q[i].pop_front();
            in_valid_i[i]    <= 1'b1;
            in_commtype_i[i] <= f.ct;
            in_last_i[i]     <= f.last;
            in_dst_i[i]      <= f.dst;
            in_payload_i[i]  <= f.payload;
          end else begin
            in_valid_i[i] <= 1'b0;
          end
        end
      end
      if (bp_en) begin
        out_ready_i <= (($random(seed) & 3) != 0);
      end else begin
        out_ready_i <= 1'b1;
      end
    end
  end

  // Mid-cycle sampling of handshakes and output flits
  always @(negedge clk_i) begin
    route_fire = in_valid_i & in_ready_o;
    if (rst_n_i && out_valid_o && out_ready_i) begin
      captured.push_back({out_commtype_o, out_last_o, out_dst_o, out_payload_o});
    end
  end

  task automatic end_with_failure();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_payload(input string name, input noc_out_pkg::payload_t want,
                               input noc_out_pkg::payload_t got);
    if (got !== want) begin
      $display("CHECK FAILED %s: payload expected %h, actual %h", name, want, got);
      end_with_failure();
    end
  endtask

  task automatic check_dst(input string name, input noc_out_pkg::node_id_t want,
                           input noc_out_pkg::node_id_t got);
    if (got !== want) begin
      $display("CHECK FAILED %s: dst expected %h, actual %h", name, want, got);
      end_with_failure();
    end
  endtask

  task automatic check_commtype(input string name, input noc_out_pkg::commtype_e want,
                                input noc_out_pkg::commtype_e got);
    if (got !== want) begin
      $display("CHECK FAILED %s: commtype expected %s, actual %s (%b)",
               name, want.name(), got.name(), got);
      end_with_failure();
    end
  endtask

  task automatic check_count(input string name, input noc_out_pkg::count_t want,
                             input noc_out_pkg::count_t got);
    if (got !== want) begin
      $display("CHECK FAILED %s: count expected %0d, actual %0d", name, want, got);
      end_with_failure();
    end
  endtask

  task automatic check_apb_data(input string name, input noc_out_pkg::apb_data_t want,
                                input noc_out_pkg::apb_data_t got);
    if (got !== want) begin
      $display("CHECK FAILED %s: data expected %h, actual %h", name, want, got);
      end_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic want, input logic got);
    if (got !== want) begin
      $display("CHECK FAILED %s: flag expected %b, actual %b", name, want, got);
      end_with_failure();
    end
  endtask

  task automatic apb_write(input logic [`NOC_APB_AW-1:0] addr,
                           input noc_out_pkg::apb_data_t data);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b1;
    paddr_i   <= addr;
    pwdata_i  <= data;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
  endtask

  task automatic apb_read(input logic [`NOC_APB_AW-1:0] addr,
                          output noc_out_pkg::apb_data_t data, output logic err);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
    paddr_i   <= addr;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(negedge clk_i);
    data = prdata_o;
    err  = pslverr_o;
    check_flag("apb pready", 1'b1, pready_o);
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  // Payload holds route, packet and flit index so the stream can be traced
  task automatic send_unicast_packet(input int route, input int pkt, input int len);
    flit_t f;
    for (int k = 0; k < len; k++) begin
      f.ct      = noc_out_pkg::UNICAST;
      f.last    = (k == len - 1);
      f.dst     = {4'(route), 4'(pkt)};
      f.payload = {8'(route), 8'(pkt), 8'(k), 8'h3C};
      route_q[route].push_back(f);
      exp_q[route].push_back(f);
    end
    exp_ucnt += noc_out_pkg::count_t'(len);
  endtask

  task automatic push_reduce_flit(input int route, input noc_out_pkg::payload_t value);
    flit_t f;
    f.ct      = noc_out_pkg::REDUCE;
    f.last    = 1'b1;
    f.dst     = {4'(route), 4'hF};
    f.payload = value;
    route_q[route].push_back(f);
  endtask

  function automatic logic routes_idle();
    logic idle;
    idle = 1'b1;
    for (int i = 0; i < NUM; i++) begin
      if (route_q[i].size() != 0 || in_valid_i[i]) begin
        idle = 1'b0;
      end
    end
    return idle;
  endfunction

  task automatic wait_routes_idle();
    while (!routes_idle()) @(negedge clk_i);
    repeat (3) @(negedge clk_i);
  endtask

  // Reference fold starting from each operator's identity value
  function automatic noc_out_pkg::payload_t fold_members(
      input noc_out_pkg::redop_e op, input noc_out_pkg::route_vec_t mask,
      input noc_out_pkg::payload_t vals [NUM]);
    noc_out_pkg::payload_t acc;
    acc = (op == noc_out_pkg::RED_AND) ? '1 : '0;
    for (int i = 0; i < NUM; i++) begin
      if (mask[i]) begin
        case (op)
          noc_out_pkg::RED_ADD: acc = acc + vals[i];
          noc_out_pkg::RED_AND: acc = acc & vals[i];
          noc_out_pkg::RED_OR:  acc = acc | vals[i];
          default:              acc = (vals[i] > acc) ? vals[i] : acc;
        endcase
      end
    end
    return acc;
  endfunction

  // Every packet must leave whole, in per-route order, and none may be missing
  task automatic check_unicast_stream(input string name);
    int    r;
    logic  in_pkt;
    flit_t got;
    flit_t want;
    in_pkt = 1'b0;
    r      = 0;
    while (captured.size() > 0) begin
      got = captured.pop_front();
      if (!in_pkt) begin
        r = int'(got.payload[31:24]);
        if (r >= NUM || exp_q[r].size() == 0) begin
          $display("%s: output flit %h belongs to no pending packet", name, got.payload);
          end_with_failure();
        end
        in_pkt = 1'b1;
      end
      want = exp_q[r].pop_front();
      check_commtype(name, want.ct, got.ct);
      check_payload(name, want.payload, got.payload);
      check_dst(name, want.dst, got.dst);
      check_flag({name, " last"}, want.last, got.last);
      if (got.last) begin
        in_pkt = 1'b0;
      end
    end
    if (in_pkt) begin
      $display("%s: output stream ended in the middle of a packet", name);
      end_with_failure();
    end
    for (int i = 0; i < NUM; i++) begin
      check_count({name, " flits not delivered"}, '0, noc_out_pkg::count_t'(exp_q[i].size()));
    end
  endtask

  task automatic test_register_access();
    noc_out_pkg::apb_data_t data;
    logic                   err;
    apb_read(`NOC_REG_REDOP, data, err);
    check_apb_data("regs reset REDOP", noc_out_pkg::apb_data_t'(noc_out_pkg::RED_ADD), data);
    check_flag("regs mapped pslverr", 1'b0, err);
    apb_read(`NOC_REG_MASK, data, err);
    check_apb_data("regs reset MASK", noc_out_pkg::apb_data_t'({NUM{1'b1}}), data);
    apb_read(`NOC_REG_UCNT, data, err);
    check_count("regs reset UCNT", '0, noc_out_pkg::count_t'(data));
    apb_read(`NOC_REG_RCNT, data, err);
    check_count("regs reset RCNT", '0, noc_out_pkg::count_t'(data));
    apb_write(`NOC_REG_REDOP, noc_out_pkg::apb_data_t'(noc_out_pkg::RED_MAX));
    apb_write(`NOC_REG_MASK, 32'h0000_000A);
    apb_read(`NOC_REG_REDOP, data, err);
    check_apb_data("regs REDOP readback", noc_out_pkg::apb_data_t'(noc_out_pkg::RED_MAX), data);
    apb_read(`NOC_REG_MASK, data, err);
    check_apb_data("regs MASK readback", 32'h0000_000A, data);
    apb_read(4'h2, data, err);
    check_flag("regs unmapped pslverr", 1'b1, err);
  endtask

  task automatic test_single_route();
    @(negedge clk_i);
    captured.delete();
    send_unicast_packet(0, 0, 4);
    send_unicast_packet(0, 1, 1);
    send_unicast_packet(0, 2, 3);
    wait_routes_idle();
    check_unicast_stream("unicast_single_route");
  endtask

  task automatic test_contention(input int routes, input string name);
    @(negedge clk_i);
    captured.delete();
    for (int r = 0; r < routes; r++) begin
      for (int p = 0; p < 3; p++) begin
        send_unicast_packet(r, p, 1 + (r + p) % 4);
      end
    end
    wait_routes_idle();
    check_unicast_stream(name);
  endtask

  task automatic run_reduction(input noc_out_pkg::redop_e op,
                               input noc_out_pkg::route_vec_t mask);
    string                 name;
    noc_out_pkg::payload_t vals [NUM];
    int                    lowest;
    flit_t                 got;
    name = $sformatf("reduce_%s_mask_%b", op.name(), mask);
    apb_write(`NOC_REG_REDOP, noc_out_pkg::apb_data_t'(op));
    apb_write(`NOC_REG_MASK, noc_out_pkg::apb_data_t'(mask));
    @(negedge clk_i);
    captured.delete();
    lowest = -1;
    for (int i = 0; i < NUM; i++) begin
      vals[i] = noc_out_pkg::payload_t'(32'h9E37_79B9 * (i + 3) + 32'h0101_0000 * int'(op));
      if (mask[i]) begin
        if (lowest < 0) begin
          lowest = i;
        end
        push_reduce_flit(i, vals[i]);
      end
    end
    exp_rcnt += 1;
    wait_routes_idle();
    check_count({name, " flits"}, 1, noc_out_pkg::count_t'(captured.size()));
    got = captured.pop_front();
    check_commtype(name, noc_out_pkg::REDUCE, got.ct);
    check_payload(name, fold_members(op, mask, vals), got.payload);
    check_dst(name, {4'(lowest), 4'hF}, got.dst);
    check_flag({name, " last"}, 1'b1, got.last);
  endtask

  // Reduction arrives while route 0 holds the output with a 5 flit packet
  task automatic test_reduce_mid_packet();
    flit_t got;
    apb_write(`NOC_REG_REDOP, noc_out_pkg::apb_data_t'(noc_out_pkg::RED_OR));
    apb_write(`NOC_REG_MASK, 32'h0000_000C);
    @(negedge clk_i);
    captured.delete();
    send_unicast_packet(0, 0, 5);
    send_unicast_packet(0, 1, 2);
    while (captured.size() == 0) @(negedge clk_i);
    send_unicast_packet(1, 0, 2);
    push_reduce_flit(2, 32'h0000_F00F);
    push_reduce_flit(3, 32'h0A0A_0000);
    exp_rcnt += 1;
    wait_routes_idle();
    check_count("reduce_mid_packet flits", 10, noc_out_pkg::count_t'(captured.size()));
    got = captured[5];
    check_commtype("reduce_mid_packet order", noc_out_pkg::REDUCE, got.ct);
    check_payload("reduce_mid_packet", 32'h0A0A_F00F, got.payload);
    check_dst("reduce_mid_packet", {4'd2, 4'hF}, got.dst);
    captured.delete(5);
    check_unicast_stream("reduce_mid_packet unicast");
  endtask

  task automatic test_counters();
    noc_out_pkg::apb_data_t data;
    logic                   err;
    apb_read(`NOC_REG_UCNT, data, err);
    check_count("counters UCNT", exp_ucnt, noc_out_pkg::count_t'(data));
    apb_read(`NOC_REG_RCNT, data, err);
    check_count("counters RCNT", exp_rcnt, noc_out_pkg::count_t'(data));
    apb_write(`NOC_REG_UCNT, '0);
    exp_ucnt = '0;
    exp_rcnt = '0;
    apb_read(`NOC_REG_UCNT, data, err);
    check_count("counters cleared UCNT", exp_ucnt, noc_out_pkg::count_t'(data));
    apb_read(`NOC_REG_RCNT, data, err);
    check_count("counters cleared RCNT", exp_rcnt, noc_out_pkg::count_t'(data));
    @(negedge clk_i);
    captured.delete();
    send_unicast_packet(2, 0, 3);
    wait_routes_idle();
    check_unicast_stream("counters traffic");
    apb_read(`NOC_REG_UCNT, data, err);
    check_count("counters UCNT after clear", exp_ucnt, noc_out_pkg::count_t'(data));
    apb_read(`NOC_REG_RCNT, data, err);
    check_count("counters RCNT after clear", exp_rcnt, noc_out_pkg::count_t'(data));
  endtask

  initial begin
    rst_n_i   = 1'b0;
    paddr_i   = '0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    pwdata_i  = '0;
    bp_en     = 1'b0;
    exp_ucnt  = '0;
    exp_rcnt  = '0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;

    test_register_access();
    test_single_route();
    bp_en = 1'b1;
    test_contention(2, "unicast_two_routes");
    test_contention(4, "unicast_four_routes");
    bp_en = 1'b0;
    for (int o = 0; o < 4; o++) begin
      run_reduction(noc_out_pkg::redop_e'(o), 4'b1111);
      run_reduction(noc_out_pkg::redop_e'(o), 4'b0110);
    end
    test_reduce_mid_packet();
    test_counters();

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: noc_out.f
+incdir+source
source/noc_out_pkg.sv
source/flit_if.sv
source/wormhole_lock_fsm.sv
source/reduction_combiner.sv
source/traffic_counter.sv
source/port_cfg_apb.sv
source/noc_output_arbiter.sv
source/noc_output_port.sv
testbench/tb_noc_output_port.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the NoC output port testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f noc_out.f \
  --top-module tb_noc_output_port --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Verification passed" sim.log; then
  echo "Simulation PASS"
else
  echo "Simulation FAIL"
  exit 1
fi
